/* rtl/eth_parser_pkg.sv */
`default_nettype none

package eth_parser_pkg;

    // ====================
    // Widths
    // ====================
    localparam int DATA_W  = 64;                     // One beat, eight bytes
    localparam int MAC_W   = 48;
    localparam int ETYPE_W = 16;
    localparam int META_W  = 2 * MAC_W + ETYPE_W;    // {dst, src, etype} = 112
    localparam int CNT_W   = 16;                     // Statistics counters

    // ====================
    // Protocol constants
    // ====================
    localparam logic [ETYPE_W-1:0] ETYPE_IPV4 = 16'h0800;

    // Built-in test frame addresses
    localparam logic [MAC_W-1:0] GEN_DST_MAC = 48'hFFFF_FFFF_FFFF;   // Broadcast
    localparam logic [MAC_W-1:0] GEN_SRC_MAC = 48'h0200_0000_0001;   // Locally administered

    // ====================
    // State encodings
    // ====================
    // Position within the frame, parser side
    typedef enum logic [1:0] {
        PS_HDR0,        // Waiting for beat 0
        PS_HDR1,        // Waiting for beat 1
        PS_PAYLOAD      // Beats 2 and up
    } parser_state_t;

    // Test frame generator
    typedef enum logic [1:0] {
        GS_IDLE,        // Pass-through, nothing generated
        GS_HDR0,
        GS_HDR1,
        GS_PAYLOAD
    } gen_state_t;

endpackage

`default_nettype wire

/* rtl/frame_source.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_source #(
    parameter int GEN_BEATS = 8                              // Built-in frame length
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              src_sel,       // 1 = generator
    // External stream
    input  logic [eth_parser_pkg::DATA_W-1:0] s_tdata,
    input  logic                              s_tvalid,
    output logic                              s_tready,
    input  logic                              s_tlast,
    // Toward the parser
    output logic [eth_parser_pkg::DATA_W-1:0] src_tdata,
    output logic                              src_tvalid,
    input  logic                              src_tready,
    output logic                              src_tlast
);
    import eth_parser_pkg::*;

    localparam int BCNT_W = $clog2(GEN_BEATS);
    localparam logic [BCNT_W-1:0] LAST_BEAT = BCNT_W'(GEN_BEATS - 1);

    // Header beats, byte 0 in the low bits, fields big-endian
    localparam logic [DATA_W-1:0] GEN_BEAT0 = {
        GEN_SRC_MAC[39:32], GEN_SRC_MAC[47:40],               // Bytes 7..6
        GEN_DST_MAC[7:0],   GEN_DST_MAC[15:8],  GEN_DST_MAC[23:16],
        GEN_DST_MAC[31:24], GEN_DST_MAC[39:32], GEN_DST_MAC[47:40]
    };
    localparam logic [DATA_W-1:0] GEN_BEAT1 = {
        8'h00, 8'h00,                                         // Pad pair
        ETYPE_IPV4[7:0],  ETYPE_IPV4[15:8],
        GEN_SRC_MAC[7:0], GEN_SRC_MAC[15:8], GEN_SRC_MAC[23:16], GEN_SRC_MAC[31:24]
    };

    gen_state_t        gen_state;
    logic [BCNT_W-1:0] beat_cnt;     // Index of the beat on offer
    logic              gen_valid;
    logic              gen_last;
    logic              gen_fire;     // Generator beat taken
    logic [7:0]        pay_byte;
    logic [DATA_W-1:0] gen_data;

    if (GEN_BEATS < 2) begin : g_len_check
        $error("frame_source: GEN_BEATS must be at least 2");
    end

    assign gen_valid = (gen_state != GS_IDLE);
    assign gen_last  = (beat_cnt == LAST_BEAT);
    assign gen_fire  = src_sel && gen_valid && src_tready;
    assign pay_byte  = 8'(beat_cnt);                          // Payload beat k = byte k

    // ====================
    // Generator FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gen_state <= GS_IDLE;
            beat_cnt  <= '0;
        end else begin
            case (gen_state)
                GS_IDLE: begin
                    if (src_sel) begin
                        gen_state <= GS_HDR0;                 // Valid one cycle later
                        beat_cnt  <= '0;
                    end
                end
                GS_HDR0: begin
                    if (gen_fire) begin
                        gen_state <= GS_HDR1;
                        beat_cnt  <= beat_cnt + 1'b1;
                    end else if (!src_sel) begin
                        gen_state <= GS_IDLE;                 // Only between frames
                    end
                end
                GS_HDR1, GS_PAYLOAD: begin
                    if (gen_fire) begin
                        if (gen_last) begin
                            gen_state <= GS_HDR0;             // Next frame right away
                            beat_cnt  <= '0;
                        end else begin
                            gen_state <= GS_PAYLOAD;
                            beat_cnt  <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: gen_state <= GS_IDLE;
            endcase
        end
    end

    always_comb begin
        case (gen_state)
            GS_HDR0: gen_data = GEN_BEAT0;
            GS_HDR1: gen_data = GEN_BEAT1;
            default: gen_data = {8{pay_byte}};
        endcase
    end

    // ====================
    // Output select
    // ====================
    assign src_tdata  = src_sel ? gen_data  : s_tdata;
    assign src_tvalid = src_sel ? gen_valid : s_tvalid;
    assign src_tlast  = src_sel ? gen_last  : s_tlast;
    assign s_tready   = src_sel ? 1'b0      : src_tready;   // External side blocked

    // Offered beat stays up until taken, unless the source itself was switched
    a_src_valid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (src_tvalid && !src_tready) |=> (src_tvalid || (src_sel != $past(src_sel)))
    ) else $error("frame_source: src_tvalid fell before acceptance");

endmodule

`default_nettype wire

/* rtl/ethernet_frame_parser.sv */
`timescale 1ns/10ps
`default_nettype none

module ethernet_frame_parser (
    input  logic                              clk,
    input  logic                              rst_n,
    // Input stream
    input  logic [eth_parser_pkg::DATA_W-1:0] s_tdata,
    input  logic                              s_tvalid,
    output logic                              s_tready,
    input  logic                              s_tlast,
    // Output stream, one register stage
    output logic [eth_parser_pkg::DATA_W-1:0] m_tdata,
    output logic                              m_tvalid,
    input  logic                              m_tready,
    output logic                              m_tlast,
    // Header metadata {dst, src, etype}
    output logic [eth_parser_pkg::META_W-1:0] m_tuser,
    output logic                              m_tuser_valid
);
    import eth_parser_pkg::*;

    parser_state_t      state;         // Position of the next input beat
    logic               in_fire;       // Input beat accepted
    // Fields pulled out of the current input beat
    logic [MAC_W-1:0]   beat_dst;      // Beat 0 bytes 0..5
    logic [15:0]        beat_src_hi;   // Beat 0 bytes 6..7
    logic [31:0]        beat_src_lo;   // Beat 1 bytes 0..3
    logic [ETYPE_W-1:0] beat_etype;    // Beat 1 bytes 4..5
    // Held from beat 0 until beat 1 arrives
    logic [MAC_W-1:0]   dst_mac_q;
    logic [15:0]        src_hi_q;

    // Free slot or slot draining this cycle
    assign s_tready = !m_tvalid || m_tready;
    assign in_fire  = s_tvalid && s_tready;

    // ====================
    // Field extraction
    // ====================
    // Byte 0 sits lowest in the beat, fields go out MSB first
    assign beat_dst = {
        s_tdata[7:0],   s_tdata[15:8],  s_tdata[23:16],
        s_tdata[31:24], s_tdata[39:32], s_tdata[47:40]
    };
    assign beat_src_hi = {s_tdata[55:48], s_tdata[63:56]};
    assign beat_src_lo = {
        s_tdata[7:0], s_tdata[15:8], s_tdata[23:16], s_tdata[31:24]
    };
    assign beat_etype  = {s_tdata[39:32], s_tdata[47:40]};

    // ====================
    // Frame position FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PS_HDR0;
        end else if (in_fire) begin
            if (s_tlast) begin
                state <= PS_HDR0;                // Any last ends the frame, runts too
            end else begin
                case (state)
                    PS_HDR0:    state <= PS_HDR1;
                    PS_HDR1:    state <= PS_PAYLOAD;
                    PS_PAYLOAD: state <= PS_PAYLOAD;
                    default:    state <= PS_HDR0;
                endcase
            end
        end
    end

    // Beat 0 header bytes
    always_ff @(posedge clk) begin
        if (in_fire && (state == PS_HDR0)) begin
            dst_mac_q <= beat_dst;
            src_hi_q  <= beat_src_hi;
        end
    end

    // ====================
    // Output register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_tvalid      <= 1'b0;
            m_tuser_valid <= 1'b0;
        end else if (in_fire) begin
            m_tvalid      <= 1'b1;
            m_tuser_valid <= (state == PS_HDR1);   // Flags beat 1 only
        end else if (m_tready) begin
            m_tvalid      <= 1'b0;                 // Slot drained, nothing new
            m_tuser_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            m_tdata <= s_tdata;
            m_tlast <= s_tlast;
        end
    end

    // Metadata completes as beat 1 loads, holds until the next beat 1
    always_ff @(posedge clk) begin
        if (in_fire && (state == PS_HDR1)) begin
            m_tuser <= {dst_mac_q, src_hi_q, beat_src_lo, beat_etype};
        end
    end

    // ====================
    // Checks
    // ====================
    a_tuser_with_beat: assert property (
        @(posedge clk) disable iff (!rst_n)
        m_tuser_valid |-> m_tvalid
    ) else $error("parser: m_tuser_valid without m_tvalid");

    // Stalled beat keeps its data, last and metadata
    a_stall_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tlast)
                                     && $stable(m_tuser_valid) && $stable(m_tuser))
    ) else $error("parser: output changed while stalled");

endmodule

`default_nettype wire

/* rtl/frame_stats.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_stats (
    input  logic                               clk,
    input  logic                               rst_n,
    // Parser output handshake, observed only
    input  logic                               m_tvalid,
    input  logic                               m_tready,
    input  logic                               m_tlast,
    input  logic                               m_tuser_valid,
    input  logic [eth_parser_pkg::ETYPE_W-1:0] etype,
    // Counters and board LEDs
    output logic [eth_parser_pkg::CNT_W-1:0]   frame_count,
    output logic [eth_parser_pkg::CNT_W-1:0]   ipv4_count,
    output logic [eth_parser_pkg::CNT_W-1:0]   runt_count,
    output logic [3:0]                         led
);
    import eth_parser_pkg::*;

    logic out_fire;     // Beat leaves the parser
    logic last_fire;    // Frame completes
    logic meta_seen;    // Metadata already passed in this frame
    logic has_meta;     // Including the beat leaving now
    logic frame_tgl;
    logic ipv4_seen;    // Sticky since reset
    logic runt_seen;    // Sticky since reset

    assign out_fire  = m_tvalid && m_tready;
    assign last_fire = out_fire && m_tlast;
    assign has_meta  = meta_seen || m_tuser_valid;   // Two-beat frames end on beat 1

    // ====================
    // Counters
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta_seen   <= 1'b0;
            frame_count <= '0;
            ipv4_count  <= '0;
            runt_count  <= '0;
            frame_tgl   <= 1'b0;
            ipv4_seen   <= 1'b0;
            runt_seen   <= 1'b0;
        end else begin
            if (last_fire) begin
                meta_seen   <= 1'b0;                 // Next frame starts clean
                frame_count <= frame_count + 1'b1;
                frame_tgl   <= !frame_tgl;
                if (!has_meta) begin
                    runt_count <= runt_count + 1'b1;   // Last on beat 0
                    runt_seen  <= 1'b1;
                end else if (etype == ETYPE_IPV4) begin
                    ipv4_count <= ipv4_count + 1'b1;
                    ipv4_seen  <= 1'b1;
                end
            end else if (out_fire && m_tuser_valid) begin
                meta_seen <= 1'b1;
            end
        end
    end

    // LED map
    assign led[0] = frame_tgl;
    assign led[1] = ipv4_seen;
    assign led[2] = runt_seen;
    assign led[3] = m_tvalid && !m_tready;           // Downstream stall

endmodule

`default_nettype wire

/* rtl/eth_parser_top.sv */
`timescale 1ns/10ps
`default_nettype none

module eth_parser_top #(
    parameter int GEN_BEATS   = 8,    // Built-in frame length in beats
    parameter int SYNC_STAGES = 4     // Reset release delay in clocks
) (
    input  logic                              clk,
    input  logic                              rst_n,          // Raw board reset
    input  logic                              src_sel,        // 1 = test generator
    // External input stream
    input  logic [eth_parser_pkg::DATA_W-1:0] s_tdata,
    input  logic                              s_tvalid,
    output logic                              s_tready,
    input  logic                              s_tlast,
    // Parsed output stream
    output logic [eth_parser_pkg::DATA_W-1:0] m_tdata,
    output logic                              m_tvalid,
    input  logic                              m_tready,
    output logic                              m_tlast,
    output logic [eth_parser_pkg::META_W-1:0] m_tuser,
    output logic                              m_tuser_valid,
    // Statistics
    output logic [eth_parser_pkg::CNT_W-1:0]  frame_count,
    output logic [eth_parser_pkg::CNT_W-1:0]  ipv4_count,
    output logic [eth_parser_pkg::CNT_W-1:0]  runt_count,
    output logic [3:0]                        led
);
    import eth_parser_pkg::*;

    // ====================
    // Reset synchronizer
    // ====================
    logic [SYNC_STAGES-1:0] rst_sync_q;
    logic                   rst_n_sync;

    // Assert at once, release after SYNC_STAGES edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_sync_q <= '0;
        end else begin
            rst_sync_q <= {rst_sync_q[SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign rst_n_sync = rst_sync_q[SYNC_STAGES-1];

    // Source to parser
    logic [DATA_W-1:0] src_tdata;
    logic              src_tvalid;
    logic              src_tready;
    logic              src_tlast;

    // ====================
    // Datapath
    // ====================
    frame_source #(
        .GEN_BEATS (GEN_BEATS)
    ) u_source (
        .clk        (clk),
        .rst_n      (rst_n_sync),
        .src_sel    (src_sel),
        .s_tdata    (s_tdata),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .s_tlast    (s_tlast),
        .src_tdata  (src_tdata),
        .src_tvalid (src_tvalid),
        .src_tready (src_tready),
        .src_tlast  (src_tlast)
    );

    ethernet_frame_parser u_parser (
        .clk           (clk),
        .rst_n         (rst_n_sync),
        .s_tdata       (src_tdata),
        .s_tvalid      (src_tvalid),
        .s_tready      (src_tready),
        .s_tlast       (src_tlast),
        .m_tdata       (m_tdata),
        .m_tvalid      (m_tvalid),
        .m_tready      (m_tready),
        .m_tlast       (m_tlast),
        .m_tuser       (m_tuser),
        .m_tuser_valid (m_tuser_valid)
    );

    // Monitors the output handshake, ethertype is the low field of m_tuser
    frame_stats u_stats (
        .clk           (clk),
        .rst_n         (rst_n_sync),
        .m_tvalid      (m_tvalid),
        .m_tready      (m_tready),
        .m_tlast       (m_tlast),
        .m_tuser_valid (m_tuser_valid),
        .etype         (m_tuser[ETYPE_W-1:0]),
        .frame_count   (frame_count),
        .ipv4_count    (ipv4_count),
        .runt_count    (runt_count),
        .led           (led)
    );

endmodule

`default_nettype wire

/* sim/tb_eth_parser_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_eth_parser_top;

    // ====================
    // Setup
    // ====================
    localparam int CLK_PERIOD   = 20;
    localparam int GEN_BEATS    = 6;
    localparam int SYNC_STAGES  = 4;
    localparam int N_FRAMES     = 8;      // Table entries
    localparam int GEN_FRAMES   = 3;      // Generator frames to collect
    localparam int STALL_MARGIN = 8;      // Cycles allowed per beat
    localparam int SETUP_CYCLES = 100;    // Resets and drain

    // Reference values of the built-in frame
    localparam logic [47:0] REF_GEN_DST = 48'hFFFF_FFFF_FFFF;
    localparam logic [47:0] REF_GEN_SRC = 48'h0200_0000_0001;
    localparam logic [15:0] REF_IPV4    = 16'h0800;

    localparam int PH_IDLE = 0;
    localparam int PH_PASS = 1;           // External stream drives the DUT
    localparam int PH_GEN  = 2;           // Built-in generator drives the DUT

    logic         clk = 1'b0;
    logic         rst_n;
    logic         src_sel;
    logic [63:0]  s_tdata;
    logic         s_tvalid;
    logic         s_tready;
    logic         s_tlast;
    logic [63:0]  m_tdata;
    logic         m_tvalid;
    logic         m_tready;
    logic         m_tlast;
    logic [111:0] m_tuser;
    logic         m_tuser_valid;
    logic [15:0]  frame_count;
    logic [15:0]  ipv4_count;
    logic [15:0]  runt_count;
    logic [3:0]   led;

    // Stimulus table, one frame per entry
    logic [47:0]  tbl_dst   [N_FRAMES];
    logic [47:0]  tbl_src   [N_FRAMES];
    logic [15:0]  tbl_etype [N_FRAMES];
    int           tbl_beats [N_FRAMES];

    // Input beats still to send, and the scoreboard
    logic [63:0]  in_data  [$];
    logic         in_last  [$];
    logic [63:0]  exp_data [$];
    logic         exp_last [$];
    logic         exp_tuv  [$];          // Beat 1 of a frame
    logic [111:0] exp_meta [$];
    string        exp_tag  [$];

    integer       seed;
    int           phase;
    int           watchdog_cycles;
    logic         table_ready = 1'b0;
    logic         in_taken;              // Input beat goes in at the next rising edge
    logic         was_stalled;
    logic [63:0]  held_data;
    logic         held_last;

    eth_parser_top #(
        .GEN_BEATS   (GEN_BEATS),
        .SYNC_STAGES (SYNC_STAGES)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .src_sel       (src_sel),
        .s_tdata       (s_tdata),
        .s_tvalid      (s_tvalid),
        .s_tready      (s_tready),
        .s_tlast       (s_tlast),
        .m_tdata       (m_tdata),
        .m_tvalid      (m_tvalid),
        .m_tready      (m_tready),
        .m_tlast       (m_tlast),
        .m_tuser       (m_tuser),
        .m_tuser_valid (m_tuser_valid),
        .frame_count   (frame_count),
        .ipv4_count    (ipv4_count),
        .runt_count    (runt_count),
        .led           (led)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Helpers
    // ====================
    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic set_entry(input int idx, input logic [47:0] dst, input logic [47:0] src,
                             input logic [15:0] etype, input int beats);
        tbl_dst[idx]   = dst;
        tbl_src[idx]   = src;
        tbl_etype[idx] = etype;
        tbl_beats[idx] = beats;
    endtask

    task automatic load_table();
        set_entry(0, 48'h001A_2B3C_4D5E, 48'h0211_2233_4455, 16'h0800, 4);
        set_entry(1, 48'hFFFF_FFFF_FFFF, 48'h0A0B_0C0D_0E0F, 16'h0800, 1);  // Runt
        set_entry(2, 48'h0100_5E00_0001, 48'h0011_2233_4455, 16'h0800, 2);  // Ends on beat 1
        set_entry(3, 48'h3333_0000_0001, 48'h0266_7788_99AA, 16'h86DD, 5);  // IPv6
        set_entry(4, 48'hFFFF_FFFF_FFFF, 48'h00DE_ADBE_EF01, 16'h0806, 3);  // ARP
        set_entry(5, 48'h0123_4567_89AB, 48'hCDEF_0123_4567, 16'h0000, 1);  // Runt
        set_entry(6, 48'h00AA_BBCC_DDEE, 48'h0255_6677_8899, 16'h0800, 9);
        set_entry(7, 48'h0080_C200_000E, 48'h0200_0000_00FE, 16'h0800, 2);
    endtask

    // Beat 0: dst MAC in bytes 0..5, first two src bytes in 6..7
    function automatic logic [63:0] hdr_beat0(input logic [47:0] dst, input logic [47:0] src);
        logic [63:0] b;
        for (int i = 0; i < 6; i++) begin
            b[8*i +: 8] = dst[47-8*i -: 8];    // Big-endian field
        end
        b[55:48] = src[47:40];
        b[63:56] = src[39:32];
        return b;
    endfunction

    // Beat 1: last four src bytes, ethertype, then two filler bytes
    function automatic logic [63:0] hdr_beat1(input logic [47:0] src, input logic [15:0] etype,
                                              input logic [15:0] pad);
        logic [63:0] b;
        for (int i = 0; i < 4; i++) begin
            b[8*i +: 8] = src[31-8*i -: 8];
        end
        b[39:32] = etype[15:8];
        b[47:40] = etype[7:0];
        b[55:48] = pad[15:8];
        b[63:56] = pad[7:0];
        return b;
    endfunction

    task automatic push_expected(input logic [63:0] data, input logic last, input logic tuv,
                                 input logic [111:0] meta, input string tag);
        exp_data.push_back(data);
        exp_last.push_back(last);
        exp_tuv.push_back(tuv);
        exp_meta.push_back(meta);
        exp_tag.push_back(tag);
    endtask

    // Table entry to input beats, random payload
    task automatic queue_frame(input int idx);
        logic [63:0]  beat;
        logic [31:0]  rnd_lo;
        logic [31:0]  rnd_hi;
        logic         last;
        logic [111:0] meta;
        meta = {tbl_dst[idx], tbl_src[idx], tbl_etype[idx]};
        for (int b = 0; b < tbl_beats[idx]; b++) begin
            rnd_lo = $random(seed);
            rnd_hi = $random(seed);
            if (b == 0) begin
                beat = hdr_beat0(tbl_dst[idx], tbl_src[idx]);
            end else if (b == 1) begin
                beat = hdr_beat1(tbl_src[idx], tbl_etype[idx], rnd_lo[15:0]);
            end else begin
                beat = {rnd_hi, rnd_lo};
            end
            last = (b == tbl_beats[idx] - 1);
            in_data.push_back(beat);
            in_last.push_back(last);
            push_expected(beat, last, (b == 1), meta,
                          $sformatf("pass frame %0d beat %0d", idx, b));
        end
    endtask

    // Built-in frame, payload beat k is byte k repeated
    task automatic queue_gen_frame(input int n);
        logic [63:0] beat;
        for (int b = 0; b < GEN_BEATS; b++) begin
            if (b == 0) begin
                beat = hdr_beat0(REF_GEN_DST, REF_GEN_SRC);
            end else if (b == 1) begin
                beat = hdr_beat1(REF_GEN_SRC, REF_IPV4, 16'h0000);
            end else begin
                beat = {8{8'(b)}};
            end
            push_expected(beat, (b == GEN_BEATS - 1), (b == 1),
                          {REF_GEN_DST, REF_GEN_SRC, REF_IPV4},
                          $sformatf("gen frame %0d beat %0d", n, b));
        end
    endtask

    task automatic check_output_beat();
        string        tag;
        logic         tuv;
        logic [111:0] meta;
        if (exp_data.size() == 0) begin
            abort_run("An output beat arrived while no beat was expected");
        end else begin
            tag  = exp_tag.pop_front();
            tuv  = exp_tuv.pop_front();
            meta = exp_meta.pop_front();
            check_value({tag, " data"}, 128'(exp_data.pop_front()), 128'(m_tdata));
            check_value({tag, " last"}, 128'(exp_last.pop_front()), 128'(m_tlast));
            check_value({tag, " tuser_valid"}, 128'(tuv), 128'(m_tuser_valid));
            if (tuv) begin
                check_value({tag, " tuser"}, 128'(meta), 128'(m_tuser));
            end
        end
    endtask

    // Reset for 3 cycles, then wait out the synchronizer
    task automatic apply_reset(input logic sel);
        @(negedge clk);
        rst_n   = 1'b0;
        src_sel = sel;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (SYNC_STAGES + 1) @(negedge clk);
    endtask

    // ====================
    // Driver and monitor
    // ====================
    // Drive on the falling edge, sample a quarter period later
    always @(negedge clk) begin
        logic [31:0] rnd;
        if (phase == PH_PASS) begin
            if (!s_tvalid || in_taken) begin
                if (in_data.size() != 0) begin
                    s_tdata  = in_data.pop_front();
                    s_tlast  = in_last.pop_front();
                    s_tvalid = 1'b1;
                end else begin
                    s_tvalid = 1'b0;
                    s_tlast  = 1'b0;
                end
            end
        end else begin
            s_tvalid = 1'b0;
        end
        rnd      = $random(seed);
        // Pass-through keeps draining, so a stray beat shows up
        m_tready = ((phase == PH_PASS) || (exp_data.size() != 0))
                   && (rnd[1:0] != 2'b00);                          // Stall about 1 in 4

        #(CLK_PERIOD / 4);
        in_taken = s_tvalid && s_tready;
        if (was_stalled) begin
            check_value("stalled beat valid", 128'(1), 128'(m_tvalid));
            check_value("stalled beat data", 128'(held_data), 128'(m_tdata));
            check_value("stalled beat last", 128'(held_last), 128'(m_tlast));
        end
        if (m_tvalid && m_tready) begin
            check_output_beat();
        end
        was_stalled = m_tvalid && !m_tready;
        held_data   = m_tdata;
        held_last   = m_tlast;
    end

    // Watchdog sized from the beat total
    initial begin
        wait (table_ready);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles, the output stream stopped",
                            watchdog_cycles));
    end

    // ====================
    // Test sequence
    // ====================
    initial begin
        int exp_ipv4;
        int exp_runts;
        int total_beats;
        seed        = 32'h917e;
        rst_n       = 1'b0;
        src_sel     = 1'b0;
        s_tdata     = '0;
        s_tvalid    = 1'b0;
        s_tlast     = 1'b0;
        m_tready    = 1'b0;
        phase       = PH_IDLE;
        in_taken    = 1'b0;
        was_stalled = 1'b0;
        held_data   = '0;
        held_last   = 1'b0;
        exp_ipv4    = 0;
        exp_runts   = 0;
        total_beats = GEN_FRAMES * GEN_BEATS;
        load_table();
        for (int i = 0; i < N_FRAMES; i++) begin
            total_beats += tbl_beats[i];
            if (tbl_beats[i] == 1) begin
                exp_runts++;
            end else if (tbl_etype[i] == 16'h0800) begin
                exp_ipv4++;
            end
        end
        watchdog_cycles = total_beats * STALL_MARGIN + SETUP_CYCLES;
        table_ready     = 1'b1;

        apply_reset(1'b0);
        check_value("reset m_tvalid", 128'(0), 128'(m_tvalid));
        check_value("reset m_tuser_valid", 128'(0), 128'(m_tuser_valid));
        check_value("reset frame_count", 128'(0), 128'(frame_count));
        check_value("reset ipv4_count", 128'(0), 128'(ipv4_count));
        check_value("reset runt_count", 128'(0), 128'(runt_count));
        check_value("reset led", 128'(0), 128'(led));

        // Pass-through with back-pressure
        @(posedge clk);
        for (int i = 0; i < N_FRAMES; i++) begin
            queue_frame(i);
        end
        phase = PH_PASS;
        while (exp_data.size() != 0) @(posedge clk);
        repeat (3) @(negedge clk);                     // Counters lag by one cycle
        check_value("pass no extra beat", 128'(0), 128'(m_tvalid));
        check_value("pass frame_count", 128'(N_FRAMES), 128'(frame_count));
        check_value("pass ipv4_count", 128'(exp_ipv4), 128'(ipv4_count));
        check_value("pass runt_count", 128'(exp_runts), 128'(runt_count));
        check_value("pass led toggle", 128'(N_FRAMES % 2), 128'(led[0]));
        check_value("pass led ipv4", 128'(exp_ipv4 != 0), 128'(led[1]));
        check_value("pass led runt", 128'(exp_runts != 0), 128'(led[2]));
        check_value("pass led stall", 128'(0), 128'(led[3]));
        phase = PH_IDLE;

        // Generator after a fresh reset
        apply_reset(1'b1);
        check_value("gen reset ipv4_count", 128'(0), 128'(ipv4_count));
        @(posedge clk);
        for (int n = 0; n < GEN_FRAMES; n++) begin
            queue_gen_frame(n);
        end
        phase = PH_GEN;
        while (exp_data.size() != 0) @(posedge clk);
        repeat (3) @(negedge clk);
        check_value("gen frame_count", 128'(GEN_FRAMES), 128'(frame_count));
        check_value("gen ipv4_count", 128'(GEN_FRAMES), 128'(ipv4_count));
        check_value("gen runt_count", 128'(0), 128'(runt_count));
        check_value("gen led toggle", 128'(GEN_FRAMES % 2), 128'(led[0]));
        check_value("gen led stall", 128'(1), 128'(led[3]));    // Next frame waits

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
rtl/eth_parser_pkg.sv
rtl/frame_source.sv
rtl/ethernet_frame_parser.sv
rtl/frame_stats.sv
rtl/eth_parser_top.sv
sim/tb_eth_parser_top.sv

/* Makefile */
# Verilator flow for the Ethernet header parser harness

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_eth_parser_top
RTL_TOP   ?= eth_parser_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= FAIL: see errors above
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter rtl/%,$(SRCS))
SIM_BIN  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
